// File: sources.f
design/common.sv
design/pipe_reg.sv
design/fetch_aligner.sv
design/compressed.sv
design/fetch_frontend.sv
verif/fetch_frontend_asserts.sv
verif/fetch_frontend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module fetch_frontend_tb -Mdir obj_dir -o fetch_frontend_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output="$(./obj_dir/fetch_frontend_sim)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -Fqx "=== PASS ===" <<< "$sim_output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verif/fetch_frontend_tb.sv
`default_nettype none

module fetch_frontend_tb import common::*; ();

    localparam int PROGRAM_HALFWORDS = 600;
    localparam int TIMEOUT_CYCLES    = (PROGRAM_HALFWORDS / 2) * 8 + 100;

    logic            clk;
    logic            reset;
    logic            in_valid;
    fetch_word_t     in_word;
    logic            in_ready;
    logic            out_valid;
    expanded_instr_t out_instr;
    logic            out_ready;

    logic [31:0]     rng_state;
    logic [15:0]     prog_hw[$];    // Program image, one halfword per entry
    expanded_instr_t expect_q[$];
    int              word_count;
    int              next_word;
    int              cycles;
    int              mismatches;
    int              unexpected;
    int              missing;
    int              timeouts;
    int              assert_fails;

    fetch_frontend u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_instr (out_instr),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Draws one compressed encoding and the 32-bit form the spec gives it
    task automatic make_compressed(input logic bad, output logic [15:0] hw,
                                   output logic [31:0] word32);
        logic [31:0] r;
        logic [31:0] kind;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdf;
        logic [4:0]  rs1f;
        logic [5:0]  imm6;
        logic [6:0]  off7;
        logic [11:0] immx;
        logic [4:0]  f3q;
        r    = next_rand();
        kind = next_rand() % 32'd15;
        rd   = r[4:0];
        rs2  = (r[9:5] == 5'd0) ? 5'd1 : r[9:5];   // C.ADD and C.MV need rs2 != 0
        rdf  = {2'b01, r[12:10]};
        rs1f = {2'b01, r[15:13]};
        imm6 = r[21:16];
        off7 = {r[26:22], 2'b00};
        immx = {{6{imm6[5]}}, imm6};
        word32 = NOP_INSTRUCTION;
        if (bad)
        begin
            case (kind % 32'd9)
                32'd0:   f3q = 5'b000_00;   // C.ADDI4SPN
                32'd1:   f3q = 5'b001_00;
                32'd2:   f3q = 5'b101_00;
                32'd3:   f3q = 5'b001_01;   // C.JAL
                32'd4:   f3q = 5'b101_01;   // C.J
                32'd5:   f3q = 5'b110_01;   // C.BEQZ
                32'd6:   f3q = 5'b111_01;
                32'd7:   f3q = 5'b010_10;   // C.LWSP
                default: f3q = 5'b110_10;   // C.SWSP
            endcase
            hw = {f3q[4:2], r[26:16], f3q[1:0]};
            return;
        end
        case (kind)
            32'd0:
            begin
                hw     = {3'b010, off7[5:3], r[15:13], off7[2], off7[6], r[12:10], 2'b00};
                word32 = {5'b0, off7, rs1f, 3'b010, rdf, 7'h03};
            end
            32'd1:
            begin
                hw     = {3'b110, off7[5:3], r[15:13], off7[2], off7[6], r[12:10], 2'b00};
                word32 = {5'b0, off7[6:5], rdf, rs1f, 3'b010, off7[4:0], 7'h23};
            end
            32'd2:
            begin
                hw     = {3'b000, 1'b0, rd, imm6[4:0], 2'b10};
                word32 = {7'b0, imm6[4:0], rd, 3'b001, rd, 7'h13};
            end
            32'd3:
            begin
                hw     = {3'b100, 1'b1, rd, rs2, 2'b10};
                word32 = {7'b0, rs2, rd, 3'b000, rd, 7'h33};
            end
            32'd4:
            begin
                hw     = {3'b100, 1'b0, rd, rs2, 2'b10};
                word32 = {7'b0, rs2, 5'd0, 3'b000, rd, 7'h33};
            end
            32'd5:
            begin
                hw     = {3'b000, imm6[5], rd, imm6[4:0], 2'b01};
                word32 = {immx, rd, 3'b000, rd, 7'h13};
            end
            32'd6:
            begin
                hw     = {3'b010, imm6[5], rd, imm6[4:0], 2'b01};
                word32 = {immx, 5'd0, 3'b000, rd, 7'h13};
            end
            32'd7:
            begin
                if (rd == 5'd0 || rd == 5'd2)   // x2 would be C.ADDI16SP
                    rd = 5'd3;
                if (imm6 == 6'd0)
                    imm6 = 6'd1;
                hw     = {3'b011, imm6[5], rd, imm6[4:0], 2'b01};
                word32 = {{14{imm6[5]}}, imm6, rd, 7'h37};
            end
            32'd8, 32'd9, 32'd10:
            begin
                if (kind == 32'd10)
                begin
                    hw     = {3'b100, imm6[5], 2'b10, r[15:13], imm6[4:0], 2'b01};
                    word32 = {immx, rs1f, 3'b111, rs1f, 7'h13};
                end
                else
                begin
                    // Shifts keep shamt[5] clear for RV32
                    hw     = {3'b100, 1'b0, kind[1:0], r[15:13], imm6[4:0], 2'b01};
                    word32 = {1'b0, kind[0], 5'b0, imm6[4:0], rs1f, 3'b101, rs1f, 7'h13};
                end
            end
            default:
            begin
                hw = {3'b100, 1'b0, 2'b11, r[15:13], 2'(kind - 32'd11), r[12:10], 2'b01};
                case (kind)
                    32'd11:  word32 = {7'b0100000, rdf, rs1f, 3'b000, rs1f, 7'h33};
                    32'd12:  word32 = {7'b0, rdf, rs1f, 3'b100, rs1f, 7'h33};
                    32'd13:  word32 = {7'b0, rdf, rs1f, 3'b110, rs1f, 7'h33};
                    default: word32 = {7'b0, rdf, rs1f, 3'b111, rs1f, 7'h33};
                endcase
            end
        endcase
    endtask

    task automatic build_program();
        logic [31:0]     pick;
        logic [31:0]     word32;
        logic [15:0]     hw;
        logic [XLEN-1:0] pc;
        pc = RESET_PC;
        while (prog_hw.size() < PROGRAM_HALFWORDS)
        begin
            pick = next_rand() % 32'd10;
            if (pick < 32'd4)
            begin
                word32 = next_rand();
                word32[1:0] = 2'b11;
                prog_hw.push_back(word32[15:0]);
                prog_hw.push_back(word32[31:16]);
                expect_q.push_back('{pc: pc, instruction: word32, is_compressed: 1'b0,
                                     illegal: 1'b0});
                pc = pc + 32'd4;
            end
            else
            begin
                make_compressed(pick == 32'd9, hw, word32);
                prog_hw.push_back(hw);
                expect_q.push_back('{pc: pc, instruction: word32, is_compressed: 1'b1,
                                     illegal: pick == 32'd9});
                pc = pc + 32'd2;
            end
        end
        // Spare halfword opens a 32-bit no-op that never completes
        if (prog_hw.size() % 2 != 0)
            prog_hw.push_back(NOP_INSTRUCTION[15:0]);
        word_count = prog_hw.size() / 2;
    endtask

    task automatic compare_field(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
        if (want !== got)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, want, got);
            mismatches++;
        end
    endtask

    task automatic compare_instr(input expanded_instr_t want, input expanded_instr_t got);
        compare_field("out_instr.pc", want.pc, got.pc);
        compare_field("out_instr.instruction", want.instruction, got.instruction);
        compare_field("out_instr.is_compressed", 32'(want.is_compressed),
                      32'(got.is_compressed));
        compare_field("out_instr.illegal", 32'(want.illegal), 32'(got.illegal));
    endtask

    always @(posedge clk)
    begin : drive_inputs
        logic [31:0] r;
        r = next_rand();
        out_ready <= r[7:0] < 8'd179;   // About 70%
        if (!reset)
        begin
            if (in_valid && in_ready)
                next_word = next_word + 1;
            if (!in_valid || in_ready)
            begin
                if (next_word < word_count && r[19:16] > 4'd3)
                begin
                    in_valid <= 1'b1;
                    in_word  <= '{addr: RESET_PC + XLEN'(next_word * 4),
                                  data: {prog_hw[2 * next_word + 1], prog_hw[2 * next_word]}};
                end
                else
                    in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (!reset && out_valid && out_ready)
        begin
            if (expect_q.size() == 0)
            begin
                $display("Unexpected output at pc %h after the last instruction", out_instr.pc);
                unexpected++;
            end
            else
                compare_instr(expect_q.pop_front(), out_instr);
        end
    end

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_word    = '0;
        out_ready  = 1'b0;
        rng_state  = 32'h575a;
        next_word  = 0;
        cycles     = 0;
        mismatches = 0;
        unexpected = 0;
        timeouts   = 0;
        build_program();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (expect_q.size() != 0 && cycles < TIMEOUT_CYCLES)
            @(posedge clk);
        if (expect_q.size() != 0)
        begin
            $display("Timeout: output stalled after %0d cycles", cycles);
            timeouts++;
        end
        repeat (20) @(posedge clk);   // Catch anything past the end
        missing = expect_q.size();
        foreach (expect_q[i])
            $display("Instruction at pc %h never arrived", expect_q[i].pc);
        assert_fails = u_dut.u_asserts.fail_count;
        $display("Errors: %0d mismatch, %0d missing, %0d unexpected, %0d timeout, %0d assertion",
                 mismatches, missing, unexpected, timeouts, assert_fails);
        if (mismatches + missing + unexpected + timeouts + assert_fails == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fetch_frontend_asserts.sv
`default_nettype none

module fetch_frontend_asserts import common::*; (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            in_valid,
    input wire fetch_word_t     in_word,
    input wire logic            in_ready,
    input wire logic            out_valid,
    input wire expanded_instr_t out_instr,
    input wire logic            out_ready,
    input wire logic            aln_valid,
    input wire aligned_instr_t  aln_instr,
    input wire logic            aln_ready
);

    int fail_count = 0;

    // Covers every reset cycle and the first one after it
    out_idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid && !aln_valid)
    else
    begin
        fail_count = fail_count + 1;
        $error("out_valid or aln_valid high after a reset cycle");
    end

    in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_word))
    else
    begin
        fail_count = fail_count + 1;
        $error("in_word changed while waiting for in_ready");
    end

    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_instr))
    else
    begin
        fail_count = fail_count + 1;
        $error("out_instr changed while waiting for out_ready");
    end

    // Upper half may fill in behind a compressed head
    aln_hold: assert property (@(posedge clk) disable iff (reset)
        aln_valid && !aln_ready |=> aln_valid && $stable(aln_instr.pc)
                                    && $stable(aln_instr.bits[15:0]))
    else
    begin
        fail_count = fail_count + 1;
        $error("Aligner output changed while waiting for aln_ready");
    end

endmodule

bind fetch_frontend fetch_frontend_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_word   (in_word),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_instr (out_instr),
    .out_ready (out_ready),
    .aln_valid (aln_valid),
    .aln_instr (aln_instr),
    .aln_ready (aln_ready)
);

`default_nettype wire

// File: design/fetch_frontend.sv
`default_nettype none

module fetch_frontend import common::*; (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            in_valid,
    input  wire fetch_word_t     in_word,
    output logic                 in_ready,
    output logic                 out_valid,
    output expanded_instr_t      out_instr,
    input  wire logic            out_ready
);

    logic                         word_valid;
    fetch_word_t                  word;
    logic                         word_ready;
    logic                         aln_valid;
    aligned_instr_t               aln_instr;
    logic                         aln_ready;
    logic                         exp_compressed;
    logic                         exp_illegal;
    logic [INSTRUCTION_WIDTH-1:0] exp_word;
    expanded_instr_t              exp_instr;

    pipe_reg #(.payload_t(fetch_word_t)) u_in_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (in_word),
        .in_ready  (in_ready),
        .out_valid (word_valid),
        .out_data  (word),
        .out_ready (word_ready)
    );

    fetch_aligner u_aligner (
        .clk         (clk),
        .reset       (reset),
        .word_valid  (word_valid),
        .word        (word),
        .word_ready  (word_ready),
        .instr_valid (aln_valid),
        .instr       (aln_instr),
        .instr_ready (aln_ready)
    );

    compressed u_expand (
        .mem_instruction (aln_instr),
        .is_compressed   (exp_compressed),
        .illegal         (exp_illegal),
        .instruction     (exp_word)
    );

    assign exp_instr = '{pc: aln_instr.pc, instruction: exp_word,
                         is_compressed: exp_compressed, illegal: exp_illegal};

    pipe_reg #(.payload_t(expanded_instr_t)) u_out_reg (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (aln_valid),
        .in_data   (exp_instr),
        .in_ready  (aln_ready),
        .out_valid (out_valid),
        .out_data  (out_instr),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: design/compressed.sv
`default_nettype none

module compressed import common::*; (
    input  wire aligned_instr_t           mem_instruction,
    output logic                          is_compressed,
    output logic                          illegal,
    output logic [INSTRUCTION_WIDTH-1:0]  instruction
);

    logic [15:0] c;
    logic [4:0]  rd;      // Full register field
    logic [4:0]  rs2;     // Full register field, also shamt
    logic [4:0]  rd_p;    // Compact x8..x15
    logic [4:0]  rs1_p;   // Compact x8..x15
    logic [11:0] imm_i;   // Sign extended 6-bit immediate
    logic [6:0]  off_w;   // C.LW / C.SW byte offset

    assign c     = mem_instruction.bits[15:0];
    assign rd    = c[11:7];
    assign rs2   = c[6:2];
    assign rd_p  = {2'b01, c[4:2]};
    assign rs1_p = {2'b01, c[9:7]};
    assign imm_i = {{6{c[12]}}, c[12], c[6:2]};
    assign off_w = {c[5], c[12:10], c[6], 2'b00};

    always_comb
    begin : compressed_expand
        is_compressed = 1'b1;
        illegal       = 1'b1;
        instruction   = NOP_INSTRUCTION;

        case (c[1:0])
            2'b11:
            begin
                is_compressed = 1'b0;
                illegal       = 1'b0;
                instruction   = mem_instruction.bits;
            end
            2'b00:
            begin
                if (c[15:13] == 3'b010)   // C.LW
                begin
                    illegal     = 1'b0;
                    instruction = {5'b0, off_w, rs1_p, 3'b010, rd_p, 7'b0000011};
                end
                else if (c[15:13] == 3'b110)   // C.SW
                begin
                    illegal     = 1'b0;
                    instruction = {5'b0, off_w[6:5], rd_p, rs1_p, 3'b010, off_w[4:0], 7'b0100011};
                end
            end
            2'b01:
            begin
                case (c[15:13])
                    3'b000:   // C.ADDI
                    begin
                        illegal     = 1'b0;
                        instruction = {imm_i, rd, 3'b000, rd, 7'b0010011};
                    end
                    3'b010:   // C.LI
                    begin
                        illegal     = 1'b0;
                        instruction = {imm_i, 5'b0, 3'b000, rd, 7'b0010011};
                    end
                    3'b011:   // C.LUI, rd 2 is C.ADDI16SP
                    begin
                        if (rd != 5'd2)
                        begin
                            illegal     = 1'b0;
                            instruction = {{8{imm_i[11]}}, imm_i, rd, 7'b0110111};
                        end
                    end
                    3'b100:
                    begin
                        illegal = 1'b0;
                        case (c[11:10])
                            2'b00:   // C.SRLI
                                instruction = {7'b0000000, rs2, rs1_p, 3'b101, rs1_p, 7'b0010011};
                            2'b01:   // C.SRAI
                                instruction = {7'b0100000, rs2, rs1_p, 3'b101, rs1_p, 7'b0010011};
                            2'b10:   // C.ANDI
                                instruction = {imm_i, rs1_p, 3'b111, rs1_p, 7'b0010011};
                            default:
                            begin
                                case (c[6:5])
                                    2'b00:   // C.SUB
                                        instruction = {7'b0100000, rd_p, rs1_p, 3'b000, rs1_p,
                                                       7'b0110011};
                                    2'b01:   // C.XOR
                                        instruction = {7'b0, rd_p, rs1_p, 3'b100, rs1_p, 7'b0110011};
                                    2'b10:   // C.OR
                                        instruction = {7'b0, rd_p, rs1_p, 3'b110, rs1_p, 7'b0110011};
                                    default:   // C.AND
                                        instruction = {7'b0, rd_p, rs1_p, 3'b111, rs1_p, 7'b0110011};
                                endcase
                            end
                        endcase
                        // RV32 has no shamt[5] and no word ALU ops
                        if (c[12] && c[11:10] != 2'b10)   // Bit 12 is the C.ANDI sign
                        begin
                            illegal     = 1'b1;
                            instruction = NOP_INSTRUCTION;
                        end
                    end
                    default: illegal = 1'b1;   // Jumps and branches
                endcase
            end
            2'b10:
            begin
                if (c[15:13] == 3'b000 && !c[12])   // C.SLLI
                begin
                    illegal     = 1'b0;
                    instruction = {7'b0000000, rs2, rd, 3'b001, rd, 7'b0010011};
                end
                else if (c[15:13] == 3'b100 && rs2 != 5'd0)
                begin
                    illegal = 1'b0;
                    if (c[12])   // C.ADD
                        instruction = {7'b0, rs2, rd, 3'b000, rd, 7'b0110011};
                    else         // C.MV
                        instruction = {7'b0, rs2, 5'b0, 3'b000, rd, 7'b0110011};
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/fetch_aligner.sv
`default_nettype none

module fetch_aligner import common::*; (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           word_valid,
    input  wire fetch_word_t    word,
    output logic                word_ready,
    output logic                instr_valid,
    output aligned_instr_t      instr,
    input  wire logic           instr_ready
);

    logic [2:0][15:0] hw_q;      // Oldest halfword in slot 0
    logic [2:0][15:0] hw_d;
    logic [1:0]       count_q;   // Halfwords held
    logic [1:0]       count_d;
    logic [XLEN-1:0]  pc_q;      // PC of slot 0
    logic [XLEN-1:0]  pc_d;
    logic [1:0]       remain;    // Count left after a consume
    logic             head_wide;
    logic             take;
    logic             load;

    assign head_wide = hw_q[0][1:0] == 2'b11;

    // A 32-bit instruction needs both halves present
    assign instr_valid = (count_q != 2'd0 && !head_wide) || count_q >= 2'd2;
    assign instr       = '{pc: pc_q, bits: {hw_q[1], hw_q[0]}};
    assign word_ready  = count_q <= 2'd1;

    assign take = instr_valid && instr_ready;
    assign load = word_valid && word_ready;

    always_comb
    begin
        hw_d   = hw_q;
        remain = count_q;
        pc_d   = pc_q;

        if (take)
        begin
            if (head_wide)
            begin
                hw_d[0] = hw_q[2];
                remain  = count_q - 2'd2;
                pc_d    = pc_q + XLEN'(4);
            end
            else
            begin
                hw_d[0] = hw_q[1];
                hw_d[1] = hw_q[2];
                remain  = count_q - 2'd1;
                pc_d    = pc_q + XLEN'(2);
            end
        end

        count_d = remain;

        // Remain is at most 1 here, so three slots always suffice
        if (load)
        begin
            count_d = remain + 2'd2;
            if (remain == 2'd0)
            begin
                hw_d[0] = word.data[15:0];
                hw_d[1] = word.data[31:16];
                pc_d    = word.addr;   // Empty buffer restarts at the word
            end
            else
            begin
                hw_d[1] = word.data[15:0];
                hw_d[2] = word.data[31:16];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count_q <= 2'd0;
            pc_q    <= RESET_PC;
        end
        else
        begin
            count_q <= count_d;
            pc_q    <= pc_d;
        end
    end

    always_ff @(posedge clk)
    begin
        hw_q <= hw_d;
    end

endmodule

`default_nettype wire

// File: design/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          in_ready,
    output logic          out_valid,
    output payload_t      out_data,
    input  wire logic     out_ready
);

    logic load;

    assign in_ready = !out_valid || out_ready;   // Empty or draining now
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: design/common.sv
`default_nettype none

package common;

    localparam int INSTRUCTION_WIDTH = 32;
    localparam int XLEN              = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Canonical addi x0, x0, 0
    localparam logic [INSTRUCTION_WIDTH-1:0] NOP_INSTRUCTION = 32'h0000_0013;

    // One memory word from the fetch stream
    typedef struct packed {
        logic [XLEN-1:0] addr;   // Word aligned
        logic [31:0]     data;   // Low halfword at lower address
    } fetch_word_t;

    // Instruction cut out of the stream, not yet expanded
    typedef struct packed {
        logic [XLEN-1:0]              pc;
        logic [INSTRUCTION_WIDTH-1:0] bits;   // Upper half only valid if 32-bit
    } aligned_instr_t;

    typedef struct packed {
        logic [XLEN-1:0]              pc;
        logic [INSTRUCTION_WIDTH-1:0] instruction;
        logic                         is_compressed;
        logic                         illegal;
    } expanded_instr_t;

endpackage

`default_nettype wire
